//--- design/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// first fetch address after reset
`define FETCH_PC_RESET 32'h1c000000

// instruction memory depth in words
// split evenly into an even-word and an odd-word bank
`define FETCH_IMEM_WORDS 1024

// direct-mapped btb size
`define FETCH_BTB_ENTRIES 16

// fetch queue entries
// must be a power of two for pointer wrap
`define FETCH_QUEUE_DEPTH 8

// decode buffer slots
// also the credit count after reset and after a flush
`define FETCH_DEC_CREDITS 4

`endif

//--- design/fetch_pkg.sv
package fetch_pkg;

    // byte address
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // result of one fetch request
    // slot 0 is the word at pc, slot 1 the word at pc + 4
    typedef struct packed {
        addr_t        pc;
        logic [1:0]   slot_valid;
        inst_t [1:0]  inst;
        // prediction belongs to the last valid slot
        logic         pred_taken;
        addr_t        pred_target;
    } fetch_group_t;

    // one instruction as handed to decode
    typedef struct packed {
        addr_t pc;
        inst_t inst;
        // only set on the instruction that ends its group
        logic  pred_taken;
        addr_t pred_target;
    } queue_entry_t;

endpackage

//--- design/fetch_req_if.sv
`timescale 1ns/1ps

// fetch request from address generation to the memory read stage
// valid is only raised once the queue has granted room
interface fetch_req_if;
    import fetch_pkg::*;

    logic  valid;
    addr_t pc;
    // btb result for this pc
    logic  pred_taken;
    addr_t pred_target;

    // address generation side
    modport gen (
        output valid,
        output pc,
        output pred_taken,
        output pred_target
    );

    // memory read side
    modport mem (
        input valid,
        input pc,
        input pred_taken,
        input pred_target
    );

endinterface

//--- design/pc_gen.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module pc_gen (
    input  logic             clk,
    input  logic             rstn,
    input  logic             fetch_allowin,
    input  logic             set_pc_wb,
    input  fetch_pkg::addr_t pc_wb,
    input  logic             set_pc_ex,
    input  fetch_pkg::addr_t pc_ex,
    input  logic             set_pc_id,
    input  fetch_pkg::addr_t pc_id,
    input  logic             set_pc_priv,
    input  fetch_pkg::addr_t pc_priv,
    input  logic             pred_taken,
    input  fetch_pkg::addr_t pred_target,
    output fetch_pkg::addr_t lookup_pc,
    output logic             redirect,
    fetch_req_if.gen         req
);
    import fetch_pkg::*;

    // current fetch address
    addr_t pc_q;
    // sequential successor of pc_q
    addr_t seq_pc;
    // successor after prediction
    addr_t next_pc;
    // low for the first cycle out of reset
    logic  run_q;
    logic  accept;

    // any redirect flushes the fetch in flight and the queue
    assign redirect = set_pc_wb | set_pc_ex | set_pc_id | set_pc_priv;

    // request only when the queue reserved room
    // and no redirect is replacing the pc this cycle
    assign accept = run_q & fetch_allowin & ~redirect;

    // aligned pc fetches a pair, odd word pc fetches one word
    assign seq_pc  = pc_q[2] ? pc_q + 32'd4 : pc_q + 32'd8;
    assign next_pc = pred_taken ? pred_target : seq_pc;

    // btb is looked up with the group pc
    assign lookup_pc = pc_q;

    assign req.valid       = accept;
    assign req.pc          = pc_q;
    assign req.pred_taken  = pred_taken;
    assign req.pred_target = pred_target;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // redirect priority wb, ex, id, priv
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_q <= `FETCH_PC_RESET;
        end else if (set_pc_wb) begin
            pc_q <= pc_wb;
        end else if (set_pc_ex) begin
            pc_q <= pc_ex;
        end else if (set_pc_id) begin
            pc_q <= pc_id;
        end else if (set_pc_priv) begin
            pc_q <= pc_priv;
        end else if (accept) begin
            pc_q <= next_pc;
        end
        // otherwise hold while the queue is full
    end

endmodule

//--- design/branch_predictor.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module branch_predictor (
    input  logic             clk,
    input  logic             rstn,
    input  fetch_pkg::addr_t lookup_pc,
    input  logic             train_valid,
    input  fetch_pkg::addr_t train_pc,
    input  fetch_pkg::addr_t train_target,
    input  logic             train_taken,
    output logic             hit_taken,
    output fetch_pkg::addr_t target
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(`FETCH_BTB_ENTRIES);
    // word offset bits 1:0 are not part of index or tag
    localparam int TAG_W = 32 - 2 - IDX_W;

    // table state
    logic              valid_q  [`FETCH_BTB_ENTRIES];
    logic [TAG_W-1:0]  tag_q    [`FETCH_BTB_ENTRIES];
    addr_t             target_q [`FETCH_BTB_ENTRIES];
    logic              taken_q  [`FETCH_BTB_ENTRIES];

    logic [IDX_W-1:0]  lookup_idx;
    logic [TAG_W-1:0]  lookup_tag;
    logic [IDX_W-1:0]  train_idx;
    logic [TAG_W-1:0]  train_tag;

    // index sits directly above the byte offset
    assign lookup_idx = lookup_pc[2 +: IDX_W];
    assign lookup_tag = lookup_pc[31 -: TAG_W];
    assign train_idx  = train_pc[2 +: IDX_W];
    assign train_tag  = train_pc[31 -: TAG_W];

    // combinational lookup
    // taken only on a valid matching entry trained taken
    assign hit_taken = valid_q[lookup_idx]
                     & (tag_q[lookup_idx] == lookup_tag)
                     & taken_q[lookup_idx];
    assign target    = target_q[lookup_idx];

    // entry valid bits
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `FETCH_BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (train_valid) begin
            valid_q[train_idx] <= 1'b1;
        end
    end

    // entry payload
    // a not-taken training keeps the entry but clears its taken bit
    always_ff @(posedge clk) begin
        if (train_valid) begin
            tag_q[train_idx]    <= train_tag;
            target_q[train_idx] <= train_target;
            taken_q[train_idx]  <= train_taken;
        end
    end

endmodule

//--- design/inst_fetch.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module inst_fetch (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    flush,
    fetch_req_if.mem                req,
    input  logic                    imem_we,
    input  fetch_pkg::addr_t        imem_addr,
    input  fetch_pkg::inst_t        imem_wdata,
    output logic                    grp_valid,
    output fetch_pkg::fetch_group_t grp
);
    import fetch_pkg::*;

    localparam int BANK_WORDS = `FETCH_IMEM_WORDS / 2;
    localparam int BANK_AW    = $clog2(BANK_WORDS);

    // word address bit 2 picks the bank
    // an aligned pair shares one row index
    inst_t even_bank [BANK_WORDS];
    inst_t odd_bank  [BANK_WORDS];

    logic [BANK_AW-1:0] rd_idx;
    logic [BANK_AW-1:0] ld_idx;

    assign rd_idx = req.pc[3 +: BANK_AW];
    assign ld_idx = imem_addr[3 +: BANK_AW];

    // load port, used before the run starts
    always_ff @(posedge clk) begin
        if (imem_we) begin
            if (imem_addr[2]) begin
                odd_bank[ld_idx] <= imem_wdata;
            end else begin
                even_bank[ld_idx] <= imem_wdata;
            end
        end
    end

    // group valid drops on a flush
    always_ff @(posedge clk) begin
        if (!rstn) begin
            grp_valid <= 1'b0;
        end else begin
            grp_valid <= req.valid & ~flush;
        end
    end

    // one-cycle pair read into the group register
    always_ff @(posedge clk) begin
        if (req.valid) begin
            grp.pc             <= req.pc;
            // slot 1 only for an aligned pc with no taken prediction
            grp.slot_valid[0]  <= 1'b1;
            grp.slot_valid[1]  <= ~req.pc[2] & ~req.pred_taken;
            // odd word pc starts in the odd bank
            grp.inst[0]        <= req.pc[2] ? odd_bank[rd_idx] : even_bank[rd_idx];
            grp.inst[1]        <= odd_bank[rd_idx];
            grp.pred_taken     <= req.pred_taken;
            grp.pred_target    <= req.pred_target;
        end
    end

endmodule

//--- design/fetch_queue.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_queue (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    flush,
    input  logic                    grp_valid,
    input  fetch_pkg::fetch_group_t grp,
    input  logic                    credit_return,
    output logic                    fetch_allowin,
    output logic                    inst_valid,
    output fetch_pkg::queue_entry_t inst_entry
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(`FETCH_QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam int CRD_W = $clog2(`FETCH_DEC_CREDITS + 1);
    // room held for the group already in the read stage
    localparam int RESERVE   = 2;
    // largest group a new request can bring
    localparam int GROUP_MAX = 2;

    queue_entry_t entries [`FETCH_QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] wr_ptr_nx;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] free_cnt;
    logic [CRD_W-1:0] credit_q;

    logic             push;
    logic             push_two;
    logic             pop;
    queue_entry_t     ent0;
    queue_entry_t     ent1;

    // group split into one or two entries
    assign push     = grp_valid & grp.slot_valid[0] & ~flush;
    assign push_two = push & grp.slot_valid[1];
    assign wr_ptr_nx = wr_ptr_q + PTR_W'(1);

    // slot 0 ends the group when slot 1 is empty
    assign ent0.pc          = grp.pc;
    assign ent0.inst        = grp.inst[0];
    assign ent0.pred_taken  = grp.pred_taken & ~grp.slot_valid[1];
    assign ent0.pred_target = grp.pred_target;
    assign ent1.pc          = grp.pc + 32'd4;
    assign ent1.inst        = grp.inst[1];
    assign ent1.pred_taken  = grp.pred_taken;
    assign ent1.pred_target = grp.pred_target;

    // head is presented combinationally
    // one delivery per cycle, needs a credit and a filled entry
    assign inst_entry = entries[rd_ptr_q];
    assign inst_valid = ~flush & (count_q != '0) & (credit_q != '0);
    assign pop        = inst_valid;

    // room for a new pair after the in-flight reservation
    assign free_cnt      = CNT_W'(`FETCH_QUEUE_DEPTH) - count_q;
    assign fetch_allowin = free_cnt >= CNT_W'(RESERVE + GROUP_MAX);

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr_q] <= ent0;
        end
        if (push_two) begin
            entries[wr_ptr_nx] <= ent1;
        end
    end

    // pointers and occupancy cleared on flush
    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(push) + PTR_W'(push_two);
            rd_ptr_q <= rd_ptr_q + PTR_W'(pop);
            count_q  <= count_q + CNT_W'(push) + CNT_W'(push_two) - CNT_W'(pop);
        end
    end

    // decode credits
    // decode flushes on the same redirect, so returns that cycle are dropped
    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            credit_q <= CRD_W'(`FETCH_DEC_CREDITS);
        end else begin
            credit_q <= credit_q - CRD_W'(pop) + CRD_W'(credit_return);
        end
    end

endmodule

//--- design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic             clk,
    input  logic             rstn,
    input  logic             set_pc_wb,
    input  fetch_pkg::addr_t pc_wb,
    input  logic             set_pc_ex,
    input  fetch_pkg::addr_t pc_ex,
    input  logic             set_pc_id,
    input  fetch_pkg::addr_t pc_id,
    input  logic             set_pc_priv,
    input  fetch_pkg::addr_t pc_priv,
    input  logic             train_valid,
    input  fetch_pkg::addr_t train_pc,
    input  fetch_pkg::addr_t train_target,
    input  logic             train_taken,
    input  logic             imem_we,
    input  fetch_pkg::addr_t imem_addr,
    input  fetch_pkg::inst_t imem_wdata,
    input  logic             credit_return,
    output logic             inst_valid,
    output fetch_pkg::addr_t inst_pc,
    output fetch_pkg::inst_t inst_word,
    output logic             inst_pred_taken,
    output fetch_pkg::addr_t inst_pred_target
);
    import fetch_pkg::*;

    fetch_req_if  req_if ();

    addr_t        lookup_pc;
    logic         pred_taken;
    addr_t        pred_target;
    // flush from any redirect
    logic         redirect;
    logic         fetch_allowin;
    logic         grp_valid;
    fetch_group_t grp;
    queue_entry_t inst_entry;

    pc_gen pc_gen_i (
        .clk           (clk),
        .rstn          (rstn),
        .fetch_allowin (fetch_allowin),
        .set_pc_wb     (set_pc_wb),
        .pc_wb         (pc_wb),
        .set_pc_ex     (set_pc_ex),
        .pc_ex         (pc_ex),
        .set_pc_id     (set_pc_id),
        .pc_id         (pc_id),
        .set_pc_priv   (set_pc_priv),
        .pc_priv       (pc_priv),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target),
        .lookup_pc     (lookup_pc),
        .redirect      (redirect),
        .req           (req_if.gen)
    );

    branch_predictor branch_predictor_i (
        .clk          (clk),
        .rstn         (rstn),
        .lookup_pc    (lookup_pc),
        .train_valid  (train_valid),
        .train_pc     (train_pc),
        .train_target (train_target),
        .train_taken  (train_taken),
        .hit_taken    (pred_taken),
        .target       (pred_target)
    );

    inst_fetch inst_fetch_i (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (redirect),
        .req        (req_if.mem),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .grp_valid  (grp_valid),
        .grp        (grp)
    );

    fetch_queue fetch_queue_i (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (redirect),
        .grp_valid     (grp_valid),
        .grp           (grp),
        .credit_return (credit_return),
        .fetch_allowin (fetch_allowin),
        .inst_valid    (inst_valid),
        .inst_entry    (inst_entry)
    );

    // queue head out as plain ports
    assign inst_pc          = inst_entry.pc;
    assign inst_word        = inst_entry.inst;
    assign inst_pred_taken  = inst_entry.pred_taken;
    assign inst_pred_target = inst_entry.pred_target;

endmodule

//--- tb/tb_fetch_top.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module tb_fetch_top;

    // 1026 load cycles, 10 reset cycles, a 40 cycle hold and about 80 deliveries
    // at a few cycles each, with wide margin
    localparam int TIMEOUT_CYCLES = 3000;
    localparam logic [31:0] BASE = `FETCH_PC_RESET;

    logic        clk;
    logic        rstn;
    logic        set_pc_wb;
    logic [31:0] pc_wb;
    logic        set_pc_ex;
    logic [31:0] pc_ex;
    logic        set_pc_id;
    logic [31:0] pc_id;
    logic        set_pc_priv;
    logic [31:0] pc_priv;
    logic        train_valid;
    logic [31:0] train_pc;
    logic [31:0] train_target;
    logic        train_taken;
    logic        imem_we;
    logic [31:0] imem_addr;
    logic [31:0] imem_wdata;
    logic        credit_return;
    logic        inst_valid;
    logic [31:0] inst_pc;
    logic [31:0] inst_word;
    logic        inst_pred_taken;
    logic [31:0] inst_pred_target;

    // reference copies of memory and btb
    logic [31:0] mem_copy   [`FETCH_IMEM_WORDS];
    logic        btb_valid  [`FETCH_BTB_ENTRIES];
    logic [31:0] btb_pc     [`FETCH_BTB_ENTRIES];
    logic [31:0] btb_target [`FETCH_BTB_ENTRIES];
    logic        btb_taken  [`FETCH_BTB_ENTRIES];
    // expected deliveries not yet seen
    logic [31:0] exp_pc_q     [$];
    logic        exp_taken_q  [$];
    logic [31:0] exp_target_q [$];
    logic [31:0] model_pc;
    integer      seed;
    int          cycle_count;
    int          delivered;
    // consumed instructions whose credit is not back yet
    int          pending;
    logic        hold;

    fetch_top dut_i (
        .clk              (clk),
        .rstn             (rstn),
        .set_pc_wb        (set_pc_wb),
        .pc_wb            (pc_wb),
        .set_pc_ex        (set_pc_ex),
        .pc_ex            (pc_ex),
        .set_pc_id        (set_pc_id),
        .pc_id            (pc_id),
        .set_pc_priv      (set_pc_priv),
        .pc_priv          (pc_priv),
        .train_valid      (train_valid),
        .train_pc         (train_pc),
        .train_target     (train_target),
        .train_taken      (train_taken),
        .imem_we          (imem_we),
        .imem_addr        (imem_addr),
        .imem_wdata       (imem_wdata),
        .credit_return    (credit_return),
        .inst_valid       (inst_valid),
        .inst_pc          (inst_pc),
        .inst_word        (inst_word),
        .inst_pred_taken  (inst_pred_taken),
        .inst_pred_target (inst_pred_target)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: expected instructions did not arrive in time");
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR at %0t: %s expected %h actual %h", $time, name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // next fetch group of the reference path
    task automatic add_group();
        logic [3:0] idx;
        logic       hit;
        idx = model_pc[5:2];
        hit = btb_valid[idx] && (btb_pc[idx][31:2] == model_pc[31:2]) && btb_taken[idx];
        exp_pc_q.push_back(model_pc);
        if (hit) begin
            // taken group ends at its first word
            exp_taken_q.push_back(1'b1);
            exp_target_q.push_back(btb_target[idx]);
            model_pc = btb_target[idx];
        end else if (model_pc[2]) begin
            exp_taken_q.push_back(1'b0);
            exp_target_q.push_back(32'd0);
            model_pc = model_pc + 32'd4;
        end else begin
            exp_taken_q.push_back(1'b0);
            exp_target_q.push_back(32'd0);
            exp_pc_q.push_back(model_pc + 32'd4);
            exp_taken_q.push_back(1'b0);
            exp_target_q.push_back(32'd0);
            model_pc = model_pc + 32'd8;
        end
    endtask

    task automatic check_delivery();
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        if (exp_pc_q.size() == 0) begin
            add_group();
        end
        pc     = exp_pc_q.pop_front();
        taken  = exp_taken_q.pop_front();
        target = exp_target_q.pop_front();
        check_value("inst_pc", pc, inst_pc);
        check_value("inst_word", mem_copy[pc[11:2]], inst_word);
        check_value("inst_pred_taken", 32'(taken), 32'(inst_pred_taken));
        // target only meaningful on a taken instruction
        if (taken) begin
            check_value("inst_pred_target", target, inst_pred_target);
        end
    endtask

    // one clock with the decode model
    task automatic tick();
        // outputs are settled by the falling edge
        @(negedge clk);
        if (inst_valid) begin
            check_delivery();
            delivered++;
            pending++;
        end
        @(posedge clk);
        #1;
        set_pc_wb   = 1'b0;
        set_pc_ex   = 1'b0;
        set_pc_id   = 1'b0;
        set_pc_priv = 1'b0;
        train_valid = 1'b0;
        // one credit back per cycle unless decode is stalled
        credit_return = !hold && (pending > 0);
        if (credit_return) begin
            pending--;
        end
    endtask

    task automatic run_deliveries(input int n);
        int goal;
        goal = delivered + n;
        while (delivered < goal) begin
            tick();
        end
    endtask

    // wb gets base, ex base+0x40, id base+0x80, priv base+0xc0
    task automatic redirect(input logic [3:0] sel, input logic [31:0] base);
        set_pc_wb   = sel[3];
        pc_wb       = base;
        set_pc_ex   = sel[2];
        pc_ex       = base + 32'h40;
        set_pc_id   = sel[1];
        pc_id       = base + 32'h80;
        set_pc_priv = sel[0];
        pc_priv     = base + 32'hc0;
        // decode drops its buffer on the same redirect
        credit_return = 1'b0;
        pending = 0;
        exp_pc_q.delete();
        exp_taken_q.delete();
        exp_target_q.delete();
        if (sel[3]) begin
            model_pc = pc_wb;
        end else if (sel[2]) begin
            model_pc = pc_ex;
        end else if (sel[1]) begin
            model_pc = pc_id;
        end else begin
            model_pc = pc_priv;
        end
        tick();
    endtask

    task automatic train_entry(input logic [31:0] pc, input logic [31:0] target,
                               input logic taken);
        train_valid  = 1'b1;
        train_pc     = pc;
        train_target = target;
        train_taken  = taken;
        btb_valid[pc[5:2]]  = 1'b1;
        btb_pc[pc[5:2]]     = pc;
        btb_target[pc[5:2]] = target;
        btb_taken[pc[5:2]]  = taken;
    endtask

    task automatic test_sequential();
        run_deliveries(20);
    endtask

    task automatic test_odd_start();
        // priv lands on base+0x104 with bit 2 set
        redirect(4'b0001, BASE + 32'h44);
        run_deliveries(10);
    endtask

    task automatic test_prediction();
        // aligned branch pc with an odd target
        // entry is written on the redirect edge
        train_entry(BASE + 32'h200, BASE + 32'h3a4, 1'b1);
        redirect(4'b0010, BASE + 32'h160);
        run_deliveries(16);
    endtask

    task automatic test_redirect_priority();
        redirect(4'b1111, BASE + 32'h300);
        run_deliveries(8);
        // without wb, ex wins
        redirect(4'b0111, BASE + 32'h500);
        run_deliveries(8);
    endtask

    task automatic test_backpressure();
        int start;
        int held;
        hold  = 1'b1;
        start = delivered;
        repeat (40) tick();
        held = delivered - start;
        check_value("held_deliveries_within_credits", 32'd1,
                    32'(held <= `FETCH_DEC_CREDITS));
        hold = 1'b0;
        run_deliveries(12);
    endtask

    initial begin
        seed          = 32'h4051;
        cycle_count   = 0;
        delivered     = 0;
        pending       = 0;
        hold          = 1'b0;
        rstn          = 1'b0;
        set_pc_wb     = 1'b0;
        pc_wb         = 32'd0;
        set_pc_ex     = 1'b0;
        pc_ex         = 32'd0;
        set_pc_id     = 1'b0;
        pc_id         = 32'd0;
        set_pc_priv   = 1'b0;
        pc_priv       = 32'd0;
        train_valid   = 1'b0;
        train_pc      = 32'd0;
        train_target  = 32'd0;
        train_taken   = 1'b0;
        imem_we       = 1'b0;
        imem_addr     = 32'd0;
        imem_wdata    = 32'd0;
        credit_return = 1'b0;
        model_pc      = BASE;
        for (int i = 0; i < `FETCH_BTB_ENTRIES; i++) begin
            btb_valid[i] = 1'b0;
        end
        // random word mixed with its own address
        for (int k = 0; k < `FETCH_IMEM_WORDS; k++) begin
            mem_copy[k] = $random(seed) ^ (BASE + 32'(k) * 32'd4);
        end
        repeat (2) @(posedge clk);
        #1;
        // memory load while still in reset
        for (int k = 0; k < `FETCH_IMEM_WORDS; k++) begin
            imem_we    = 1'b1;
            imem_addr  = BASE + 32'(k) * 32'd4;
            imem_wdata = mem_copy[k];
            @(posedge clk);
            #1;
        end
        imem_we = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        test_sequential();
        test_odd_start();
        test_prediction();
        test_redirect_priority();
        test_backpressure();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- build.f
+incdir+design
design/fetch_pkg.sv
design/fetch_req_if.sv
design/pc_gen.sv
design/branch_predictor.sv
design/inst_fetch.sv
design/fetch_queue.sv
design/fetch_top.sv
tb/tb_fetch_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
